/* src.f */
+incdir+hw
hw/fetch_pkg.sv
hw/bpu_update_if.sv
hw/gshare_pht.sv
hw/branch_target_buf.sv
hw/return_addr_stack.sv
hw/bpu.sv
hw/ifu.sv
hw/fetch_top.sv
test/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/bpu_update_if.sv
      - hw/gshare_pht.sv
      - hw/branch_target_buf.sv
      - hw/return_addr_stack.sv
      - hw/bpu.sv
      - hw/ifu.sv
      - hw/fetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_fetch.sv

/* test/tb_fetch.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch;
  import fetch_pkg::*;

  localparam int    ClkPeriod = 40;
  localparam int    NumRand   = 40;
  localparam inst_t Nop       = 32'h0000_0013;
  localparam inst_t Beq       = 32'h0000_0063;
  localparam inst_t RetInst   = 32'h0000_8067; // jalr x0, 0(x1)

  // one table row, all dut inputs for one cycle
  typedef struct {
    addr_t      pc;
    inst_t      inst;
    logic       vld;
    logic       err;
    logic       mstall;
    logic       ex_vld;
    logic       ex_taken;
    addr_t      ex_pc;
    hist_t      ex_hist;
    jump_type_e ex_type;
    addr_t      ex_tgt;
    logic       push;
    addr_t      push_data;
    logic       flush;
    logic       ex_stall;
    logic       id_stall;
  } step_t;

  logic       clk;
  logic       rst_i;
  addr_t      inst_addr_i, ex_pc_i, ex_target_i, id_ras_push_data_i;
  inst_t      if_rdata_i;
  hist_t      ex_history_i;
  jump_type_e ex_jump_type_i;
  logic       if_rdata_valid_i, if_rdata_err_i, ram_stall_valid_mem_i;
  logic       ex_branch_valid_i, ex_branch_taken_i, id_ras_push_valid_i;
  logic       ex_stall_valid_i, if_flush_i, id_stall_i;
  logic       ram_stall_valid_if_o, bpu_pc_valid_o, pdt_res_o;
  addr_t      inst_addr_o, bpu_pc_o, pdt_pc_tag_o;
  inst_t      inst_data_o;
  trap_bus_t  trap_bus_o;
  hist_t      history_o;

  step_t      steps[$];
  step_t      s;
  int         errors;
  bit         table_ready;

  // reference model of the predictor state
  logic [1:0] m_cnt [`PHT_DEPTH];
  hist_t      m_hist;
  logic       m_btb_vld [`BTB_DEPTH];
  addr_t      m_btb_pc [`BTB_DEPTH]; // full pc, covers index and tag
  addr_t      m_btb_tgt [`BTB_DEPTH];
  jump_type_e m_btb_type [`BTB_DEPTH];
  addr_t      m_ras[$];

  fetch_top u_dut (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic step_t idle_step();
    return '{default: '0, ex_type: JT_NONE, inst: Nop};
  endfunction

  task automatic add_fetch(addr_t pc, inst_t inst, logic vld, logic err, logic mstall,
                           logic flush);
    step_t t;
    t = idle_step();
    t.pc     = pc;
    t.inst   = inst;
    t.vld    = vld;
    t.err    = err;
    t.mstall = mstall;
    t.flush  = flush;
    steps.push_back(t);
  endtask

  task automatic add_train(addr_t pc, jump_type_e jt, logic taken, hist_t hist, addr_t tgt);
    step_t t;
    t = idle_step(); // fetch side idle, memory not delivering
    t.ex_vld   = 1'b1;
    t.ex_taken = taken;
    t.ex_pc    = pc;
    t.ex_hist  = hist;
    t.ex_type  = jt;
    t.ex_tgt   = tgt;
    steps.push_back(t);
  endtask

  task automatic add_push(addr_t data);
    step_t t;
    t = idle_step();
    t.push      = 1'b1;
    t.push_data = data;
    steps.push_back(t);
  endtask

  task automatic drive_inputs(step_t t);
    inst_addr_i           <= t.pc;
    if_rdata_i            <= t.inst;
    if_rdata_valid_i      <= t.vld;
    if_rdata_err_i        <= t.err;
    ram_stall_valid_mem_i <= t.mstall;
    ex_branch_valid_i     <= t.ex_vld;
    ex_branch_taken_i     <= t.ex_taken;
    ex_pc_i               <= t.ex_pc;
    ex_history_i          <= t.ex_hist;
    ex_jump_type_i        <= t.ex_type;
    ex_target_i           <= t.ex_tgt;
    id_ras_push_valid_i   <= t.push;
    id_ras_push_data_i    <= t.push_data;
    if_flush_i            <= t.flush;
    ex_stall_valid_i      <= t.ex_stall;
    id_stall_i            <= t.id_stall;
  endtask

  task automatic flag_error(string msg);
    $display("ERROR %0t: %s", $time, msg);
    errors++;
  endtask

  // expected outputs from the model, then the model steps over the clock edge
  task automatic check_and_advance(step_t t);
    int unsigned pht_idx;
    int unsigned btb_idx;
    int unsigned upd_idx;
    logic        hit;
    logic        is_ret;
    logic        shift;
    logic        exp_pv;
    addr_t       exp_pc;
    trap_bus_t   exp_trap;

    pht_idx = ((t.pc >> 2) % `PHT_DEPTH) ^ m_hist;
    btb_idx = (t.pc >> 2) % `BTB_DEPTH;
    hit     = m_btb_vld[btb_idx] && (m_btb_pc[btb_idx][31:2] == t.pc[31:2]);
    is_ret  = t.vld && (t.inst == RetInst) && (m_ras.size() != 0);
    shift   = 1'b0;
    exp_pv  = 1'b0;
    exp_pc  = '0;
    if (is_ret) begin
      exp_pv = 1'b1;
      exp_pc = m_ras[$];
    end else if (t.vld && hit && (m_btb_type[btb_idx] == JT_JAL)) begin
      exp_pv = 1'b1;
      exp_pc = m_btb_tgt[btb_idx];
    end else if (t.vld && hit && (m_btb_type[btb_idx] == JT_BRANCH)) begin
      shift  = 1'b1;
      exp_pv = m_cnt[pht_idx][1];
      exp_pc = m_btb_tgt[btb_idx];
    end
    exp_trap = '0;
    exp_trap[`TRAP_INST_ADDR_MISALIGNED] = (t.pc[1:0] != 2'b00);
    exp_trap[`TRAP_INST_ACCESS_FAULT]    = t.err && t.vld;

    assert (inst_addr_o == t.pc && inst_data_o == t.inst && pdt_pc_tag_o == t.pc)
      else flag_error($sformatf("pass-through wrong for pc %h", t.pc));
    assert (ram_stall_valid_if_o == (!t.vld && !t.mstall))
      else flag_error($sformatf("stall request %b", ram_stall_valid_if_o));
    assert (trap_bus_o == exp_trap)
      else flag_error($sformatf("trap bus %h, expected %h", trap_bus_o, exp_trap));
    assert (bpu_pc_valid_o == exp_pv && pdt_res_o == exp_pv)
      else flag_error($sformatf("prediction %b at pc %h, expected %b", bpu_pc_valid_o,
                                t.pc, exp_pv));
    assert (!exp_pv || bpu_pc_o == exp_pc)
      else flag_error($sformatf("target %h, expected %h", bpu_pc_o, exp_pc));
    assert (history_o == m_hist)
      else flag_error($sformatf("history %b, expected %b", history_o, m_hist));

    if (shift && !t.flush && !t.ex_stall) begin
      m_hist = {m_hist[`HISLEN-2:0], m_cnt[pht_idx][1]};
    end
    if (t.push && !t.id_stall) begin
      if (is_ret && !t.flush && !t.ex_stall) begin
        m_ras[$] = t.push_data; // push with pop replaces the top
      end else begin
        m_ras.push_back(t.push_data);
        if (m_ras.size() > `RAS_DEPTH) begin
          void'(m_ras.pop_front()); // oldest entry lost
        end
      end
    end else if (is_ret && !t.flush && !t.ex_stall) begin
      void'(m_ras.pop_back());
    end
    if (t.ex_vld && t.ex_type == JT_BRANCH) begin
      upd_idx = ((t.ex_pc >> 2) % `PHT_DEPTH) ^ t.ex_hist;
      if (t.ex_taken && m_cnt[upd_idx] != 2'b11) begin
        m_cnt[upd_idx] = m_cnt[upd_idx] + 2'b01;
      end else if (!t.ex_taken && m_cnt[upd_idx] != 2'b00) begin
        m_cnt[upd_idx] = m_cnt[upd_idx] - 2'b01;
      end
    end
    if (t.ex_vld && t.ex_taken && (t.ex_type == JT_BRANCH || t.ex_type == JT_JAL)) begin
      btb_idx             = (t.ex_pc >> 2) % `BTB_DEPTH;
      m_btb_vld[btb_idx]  = 1'b1;
      m_btb_pc[btb_idx]   = t.ex_pc;
      m_btb_tgt[btb_idx]  = t.ex_tgt;
      m_btb_type[btb_idx] = t.ex_type;
    end
  endtask

  initial begin
    wait (table_ready);
    #((steps.size() + 20) * ClkPeriod);
    $display("timeout: the stimulus table did not finish in the expected time");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(40986));
    clk    = 1'b0;
    rst_i  = 1'b1;
    errors = 0;
    drive_inputs(idle_step());
    m_hist = '0;
    for (int i = 0; i < `PHT_DEPTH; i++) begin
      m_cnt[i] = 2'b01;
    end
    for (int i = 0; i < `BTB_DEPTH; i++) begin
      m_btb_vld[i] = 1'b0;
    end

    add_fetch(32'h0000_0100, Nop, 1, 0, 0, 0);
    add_fetch(32'h0000_0200, Beq, 1, 0, 0, 0); // btb still empty
    add_fetch(32'h0000_0104, Nop, 0, 0, 0, 0);
    add_fetch(32'h0000_0108, Nop, 0, 0, 1, 0); // mem stage already stalling
    add_fetch(32'h0000_010c, Nop, 1, 0, 1, 0);
    add_fetch(32'h0000_0112, Nop, 1, 0, 0, 0); // misaligned
    add_fetch(32'h0000_0114, Nop, 1, 1, 0, 0);
    add_fetch(32'h0000_0118, Nop, 0, 1, 0, 0); // error without data valid
    // branch training, flushed fetches keep the history at zero
    add_train(32'h0000_0200, JT_BRANCH, 1, '0, 32'h0000_0280);
    add_train(32'h0000_0200, JT_BRANCH, 1, '0, 32'h0000_0280);
    add_fetch(32'h0000_0200, Beq, 1, 0, 0, 1);
    add_train(32'h0000_0200, JT_BRANCH, 0, '0, 32'h0000_0280);
    add_train(32'h0000_0200, JT_BRANCH, 0, '0, 32'h0000_0280);
    add_fetch(32'h0000_0200, Beq, 1, 0, 0, 1);
    add_train(32'h0000_0200, JT_BRANCH, 1, '0, 32'h0000_0280);
    add_train(32'h0000_0200, JT_BRANCH, 1, '0, 32'h0000_0280);
    add_fetch(32'h0000_0200, Beq, 1, 0, 0, 0);
    add_fetch(32'h0000_0200, Beq, 1, 0, 0, 0); // now indexed with shifted history
    add_train(32'h0000_0244, JT_JAL, 1, '0, 32'h0000_0400);
    add_fetch(32'h0000_0244, Nop, 1, 0, 0, 0);
    // return stack
    add_push(32'h0000_1000);
    add_push(32'h0000_2000);
    for (int i = 0; i < 3; i++) begin
      add_fetch(32'h0000_0300, RetInst, 1, 0, 0, 0);
    end
    for (int i = 1; i <= 5; i++) begin
      add_push(addr_t'(i * 32'h10));
    end
    for (int i = 0; i < 5; i++) begin
      add_fetch(32'h0000_0300, RetInst, 1, 0, 0, 0);
    end
    for (int i = 0; i < NumRand; i++) begin
      s = idle_step();
      s.pc        = 32'h0000_0200 + 4 * $urandom_range(31);
      s.inst      = ($urandom_range(2) == 0) ? RetInst : $urandom();
      s.vld       = ($urandom_range(3) != 0);
      s.err       = 1'($urandom_range(1));
      s.flush     = ($urandom_range(4) == 0);
      s.ex_stall  = ($urandom_range(4) == 0);
      s.id_stall  = ($urandom_range(3) == 0);
      s.push      = 1'($urandom_range(1));
      s.push_data = $urandom() & 32'hffff_fffc;
      s.ex_vld    = 1'($urandom_range(1));
      s.ex_taken  = 1'($urandom_range(1));
      s.ex_pc     = 32'h0000_0200 + 4 * $urandom_range(31);
      s.ex_hist   = hist_t'($urandom());
      s.ex_type   = jump_type_e'($urandom_range(3));
      s.ex_tgt    = $urandom() & 32'hffff_fffc;
      steps.push_back(s);
    end
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    foreach (steps[i]) begin
      @(posedge clk);
      drive_inputs(steps[i]);
      #(ClkPeriod - 2); // just before the next edge
      check_and_advance(steps[i]);
    end

    $display("steps: %0d, errors: %0d", steps.size(), errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  fetch_pkg::addr_t      inst_addr_i,
  input  logic                  if_rdata_valid_i,
  input  fetch_pkg::inst_t      if_rdata_i,
  input  logic                  if_rdata_err_i,
  input  logic                  ram_stall_valid_mem_i,
  input  logic                  ex_branch_valid_i,
  input  logic                  ex_branch_taken_i,
  input  fetch_pkg::addr_t      ex_pc_i,
  input  fetch_pkg::hist_t      ex_history_i,
  input  fetch_pkg::jump_type_e ex_jump_type_i,
  input  fetch_pkg::addr_t      ex_target_i,
  input  logic                  id_ras_push_valid_i, // call seen in id
  input  fetch_pkg::addr_t      id_ras_push_data_i,
  input  logic                  ex_stall_valid_i,
  input  logic                  if_flush_i,
  input  logic                  id_stall_i,
  output logic                  ram_stall_valid_if_o,
  output fetch_pkg::addr_t      inst_addr_o,
  output fetch_pkg::inst_t      inst_data_o,
  output fetch_pkg::trap_bus_t  trap_bus_o,
  output fetch_pkg::addr_t      bpu_pc_o,
  output logic                  bpu_pc_valid_o,
  output logic                  pdt_res_o,
  output fetch_pkg::addr_t      pdt_pc_tag_o,
  output fetch_pkg::hist_t      history_o
);

  bpu_update_if u_upd ();

  // resolved control flow from ex
  assign u_upd.valid     = ex_branch_valid_i;
  assign u_upd.taken     = ex_branch_taken_i;
  assign u_upd.pc        = ex_pc_i;
  assign u_upd.target    = ex_target_i;
  assign u_upd.history   = ex_history_i;
  assign u_upd.jump_type = ex_jump_type_i;

  ifu u_ifu (
    .clk                  (clk),
    .rst_i                (rst_i),
    .inst_addr_i          (inst_addr_i),
    .if_rdata_valid_i     (if_rdata_valid_i),
    .if_rdata_i           (if_rdata_i),
    .if_rdata_err_i       (if_rdata_err_i),
    .ram_stall_valid_mem_i(ram_stall_valid_mem_i),
    .ram_stall_valid_if_o (ram_stall_valid_if_o),
    .inst_addr_o          (inst_addr_o),
    .inst_data_o          (inst_data_o),
    .trap_bus_o           (trap_bus_o),
    .upd                  (u_upd.dst),
    .id_ras_push_valid_i  (id_ras_push_valid_i),
    .id_ras_push_data_i   (id_ras_push_data_i),
    .ex_stall_valid_i     (ex_stall_valid_i),
    .if_flush_i           (if_flush_i),
    .id_stall_i           (id_stall_i),
    .bpu_pc_o             (bpu_pc_o),
    .bpu_pc_valid_o       (bpu_pc_valid_o),
    .pdt_res_o            (pdt_res_o),
    .pdt_pc_tag_o         (pdt_pc_tag_o),
    .history_o            (history_o)
  );

endmodule

/* hw/ifu.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module ifu (
  input  logic                 clk,
  input  logic                 rst_i,
  input  fetch_pkg::addr_t     inst_addr_i,      // from pc register
  input  logic                 if_rdata_valid_i, // memory has delivered
  input  fetch_pkg::inst_t     if_rdata_i,
  input  logic                 if_rdata_err_i,
  input  logic                 ram_stall_valid_mem_i,
  output logic                 ram_stall_valid_if_o,
  output fetch_pkg::addr_t     inst_addr_o,      // to if/id
  output fetch_pkg::inst_t     inst_data_o,
  output fetch_pkg::trap_bus_t trap_bus_o,
  bpu_update_if.dst            upd,
  input  logic                 id_ras_push_valid_i,
  input  fetch_pkg::addr_t     id_ras_push_data_i,
  input  logic                 ex_stall_valid_i,
  input  logic                 if_flush_i,
  input  logic                 id_stall_i,
  output fetch_pkg::addr_t     bpu_pc_o,         // to pc register
  output logic                 bpu_pc_valid_o,
  output logic                 pdt_res_o,
  output fetch_pkg::addr_t     pdt_pc_tag_o,
  output fetch_pkg::hist_t     history_o
);
  import fetch_pkg::*;

  trap_bus_t trap_bus;

  assign inst_addr_o = inst_addr_i;
  assign inst_data_o = if_rdata_i;

  // mem stage already stalls the pipe, so it has priority
  assign ram_stall_valid_if_o = !if_rdata_valid_i && !ram_stall_valid_mem_i;

  always_comb begin
    trap_bus = '0;
    trap_bus[`TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0]; // no compressed isa
    trap_bus[`TRAP_INST_ACCESS_FAULT]    = if_rdata_err_i && if_rdata_valid_i;
    trap_bus[`TRAP_INST_PAGE_FAULT]      = 1'b0; // no mmu
  end

  assign trap_bus_o = trap_bus;

  bpu u_bpu (
    .clk                (clk),
    .rst_i              (rst_i),
    .if_pc_i            (inst_addr_i),
    .if_inst_i          (if_rdata_i),
    .if_inst_valid_i    (if_rdata_valid_i), // word only counts once delivered
    .upd                (upd),
    .id_ras_push_valid_i(id_ras_push_valid_i),
    .id_ras_push_data_i (id_ras_push_data_i),
    .flush_valid_i      (if_flush_i),
    .ex_stall_valid_i   (ex_stall_valid_i),
    .id_stall_i         (id_stall_i),
    .pdt_pc_o           (bpu_pc_o),
    .branch_or_not_o    (bpu_pc_valid_o),
    .pdt_res_o          (pdt_res_o),
    .pdt_pc_tag_o       (pdt_pc_tag_o),
    .history_o          (history_o)
  );

endmodule

/* hw/bpu.sv */
`timescale 1ns/1ps

module bpu (
  input  logic             clk,
  input  logic             rst_i,
  input  fetch_pkg::addr_t if_pc_i,
  input  fetch_pkg::inst_t if_inst_i,
  input  logic             if_inst_valid_i,
  bpu_update_if.dst        upd,
  input  logic             id_ras_push_valid_i,
  input  fetch_pkg::addr_t id_ras_push_data_i,
  input  logic             flush_valid_i,
  input  logic             ex_stall_valid_i,
  input  logic             id_stall_i,
  output fetch_pkg::addr_t pdt_pc_o,
  output logic             branch_or_not_o,
  output logic             pdt_res_o,
  output fetch_pkg::addr_t pdt_pc_tag_o,
  output fetch_pkg::hist_t history_o
);
  import fetch_pkg::*;

  localparam inst_t RetInst = 32'h0000_8067; // jalr x0, 0(x1)

  logic       pht_taken;
  logic       btb_hit;
  addr_t      btb_target;
  jump_type_e btb_type;
  addr_t      ras_top;
  logic       ras_empty;
  logic       use_ras;
  logic       btb_branch;
  logic       btb_jal;
  logic       pred_taken;
  addr_t      pred_target;
  logic       spec_ok;

  // a return with a non-empty stack wins over the btb
  assign use_ras    = if_inst_valid_i && (if_inst_i == RetInst) && !ras_empty;
  assign btb_branch = if_inst_valid_i && !use_ras && btb_hit && (btb_type == JT_BRANCH);
  assign btb_jal    = if_inst_valid_i && !use_ras && btb_hit && (btb_type == JT_JAL);

  always_comb begin
    pred_taken  = 1'b0;
    pred_target = if_pc_i + addr_t'(4); // fall through
    if (use_ras) begin
      pred_taken  = 1'b1;
      pred_target = ras_top;
    end else if (btb_jal || (btb_branch && pht_taken)) begin
      pred_taken  = 1'b1;
      pred_target = btb_target;
    end
  end

  // no speculative state change while flushing or stalled in ex
  assign spec_ok = !flush_valid_i && !ex_stall_valid_i;

  assign pdt_pc_o        = pred_target;
  assign branch_or_not_o = pred_taken;
  assign pdt_res_o       = pred_taken;
  assign pdt_pc_tag_o    = if_pc_i;

  gshare_pht u_pht (
    .clk         (clk),
    .rst_i       (rst_i),
    .lookup_pc_i (if_pc_i),
    .spec_shift_i(btb_branch && spec_ok),
    .spec_taken_i(pht_taken),
    .upd         (upd),
    .taken_o     (pht_taken),
    .history_o   (history_o)
  );

  branch_target_buf u_btb (
    .clk        (clk),
    .rst_i      (rst_i),
    .lookup_pc_i(if_pc_i),
    .upd        (upd),
    .hit_o      (btb_hit),
    .target_o   (btb_target),
    .jump_type_o(btb_type)
  );

  return_addr_stack u_ras (
    .clk        (clk),
    .rst_i      (rst_i),
    .push_i     (id_ras_push_valid_i && !id_stall_i), // held while id stalls
    .push_data_i(id_ras_push_data_i),
    .pop_i      (use_ras && spec_ok),
    .top_o      (ras_top),
    .empty_o    (ras_empty)
  );

endmodule

/* hw/return_addr_stack.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module return_addr_stack (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             push_i,
  input  fetch_pkg::addr_t push_data_i,
  input  logic             pop_i,
  output fetch_pkg::addr_t top_o,
  output logic             empty_o
);
  import fetch_pkg::*;

  localparam int PtrW = $clog2(`RAS_DEPTH);
  localparam int CntW = $clog2(`RAS_DEPTH + 1);

  addr_t           stack_q [`RAS_DEPTH];
  logic [PtrW-1:0] sp_q;    // next free slot, wraps around
  logic [PtrW-1:0] top_idx;
  logic [CntW-1:0] count_q;
  ras_state_e      state;
  logic            pop_ok;

  always_comb begin
    if (count_q == '0) begin
      state = RAS_EMPTY;
    end else if (count_q == CntW'(`RAS_DEPTH)) begin
      state = RAS_FULL;
    end else begin
      state = RAS_PARTIAL;
    end
  end

  assign top_idx = sp_q - PtrW'(1);
  assign pop_ok  = pop_i && (state != RAS_EMPTY);
  assign top_o   = stack_q[top_idx];
  assign empty_o = (state == RAS_EMPTY);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sp_q    <= '0;
      count_q <= '0;
    end else if (push_i && !pop_ok) begin
      sp_q <= sp_q + PtrW'(1);
      if (state != RAS_FULL) begin
        count_q <= count_q + CntW'(1); // when full the oldest slot is reused
      end
    end else if (pop_ok && !push_i) begin
      sp_q    <= top_idx;
      count_q <= count_q - CntW'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      if (pop_ok) begin
        stack_q[top_idx] <= push_data_i; // push with pop replaces the top
      end else begin
        stack_q[sp_q] <= push_data_i;
      end
    end
  end

endmodule

/* hw/branch_target_buf.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_target_buf (
  input  logic                  clk,
  input  logic                  rst_i,
  input  fetch_pkg::addr_t      lookup_pc_i,
  bpu_update_if.dst             upd,
  output logic                  hit_o,
  output fetch_pkg::addr_t      target_o,
  output fetch_pkg::jump_type_e jump_type_o
);
  import fetch_pkg::*;

  localparam int IdxW = $clog2(`BTB_DEPTH);
  localparam int TagW = `XLEN - IdxW - 2;

  logic            valid_q  [`BTB_DEPTH];
  logic [TagW-1:0] tag_q    [`BTB_DEPTH];
  addr_t           target_q [`BTB_DEPTH];
  jump_type_e      type_q   [`BTB_DEPTH];
  logic [IdxW-1:0] lookup_idx;
  logic [TagW-1:0] lookup_tag;
  logic [IdxW-1:0] upd_idx;
  logic [TagW-1:0] upd_tag;
  logic            wr_en;

  assign lookup_idx = lookup_pc_i[IdxW+1:2];
  assign lookup_tag = lookup_pc_i[`XLEN-1:IdxW+2];
  assign upd_idx    = upd.pc[IdxW+1:2];
  assign upd_tag    = upd.pc[`XLEN-1:IdxW+2];

  // only taken branches and jal get an entry
  assign wr_en = upd.valid && upd.taken &&
                 ((upd.jump_type == JT_BRANCH) || (upd.jump_type == JT_JAL));

  assign hit_o       = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o    = target_q[lookup_idx];
  assign jump_type_o = type_q[lookup_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `BTB_DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd.target;
      type_q[upd_idx]   <= upd.jump_type;
    end
  end

endmodule

/* hw/gshare_pht.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module gshare_pht (
  input  logic             clk,
  input  logic             rst_i,
  input  fetch_pkg::addr_t lookup_pc_i,
  input  logic             spec_shift_i, // predicted conditional branch this cycle
  input  logic             spec_taken_i,
  bpu_update_if.dst        upd,
  output logic             taken_o,
  output fetch_pkg::hist_t history_o
);
  import fetch_pkg::*;

  localparam int IdxW = $clog2(`PHT_DEPTH);

  logic [1:0]      cnt_q [`PHT_DEPTH];
  hist_t           history_q;
  logic [IdxW-1:0] lookup_idx;
  logic [IdxW-1:0] upd_idx;
  logic            upd_en;

  // word address xor history, history zero-extended to the index width
  assign lookup_idx = lookup_pc_i[IdxW+1:2] ^ IdxW'(history_q);
  assign upd_idx    = upd.pc[IdxW+1:2] ^ IdxW'(upd.history);
  assign upd_en     = upd.valid && (upd.jump_type == JT_BRANCH);

  assign taken_o   = cnt_q[lookup_idx][1]; // msb is the direction
  assign history_o = history_q;

  // 2-bit saturating counters
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `PHT_DEPTH; i++) begin
        cnt_q[i] <= 2'b01; // weakly not taken
      end
    end else if (upd_en) begin
      if (upd.taken && (cnt_q[upd_idx] != 2'b11)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
      end else if (!upd.taken && (cnt_q[upd_idx] != 2'b00)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
      end
    end
  end

  // speculative global history, newest bit at the lsb
  always_ff @(posedge clk) begin
    if (rst_i) begin
      history_q <= '0;
    end else if (spec_shift_i) begin
      history_q <= {history_q[`HISLEN-2:0], spec_taken_i};
    end
  end

endmodule

/* hw/bpu_update_if.sv */
`timescale 1ns/1ps

interface bpu_update_if;
  import fetch_pkg::*;

  logic       valid;
  logic       taken;     // resolved direction
  addr_t      pc;        // pc of the resolved instruction
  addr_t      target;
  hist_t      history;   // history used when it was predicted
  jump_type_e jump_type;

  modport src (
    output valid, taken, pc, target, history, jump_type
  );

  modport dst (
    input valid, taken, pc, target, history, jump_type
  );

endinterface

/* hw/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`XLEN-1:0] addr_t; // pc or branch target
  typedef logic [31:0] inst_t;
  typedef logic [`HISLEN-1:0] hist_t;
  typedef logic [`TRAP_LEN-1:0] trap_bus_t;

  // same encoding as the jump type field coming back from ex
  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  // fill level of the return address stack
  typedef enum logic [1:0] {
    RAS_EMPTY,
    RAS_PARTIAL,
    RAS_FULL
  } ras_state_e;

endpackage

/* hw/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// datapath widths
`define XLEN 32
`define HISLEN 6 // global history bits

// predictor table sizes, powers of two
`define PHT_DEPTH 64
`define BTB_DEPTH 16
`define RAS_DEPTH 4

// trap bus layout, bit positions follow mcause codes
`define TRAP_LEN 16
`define TRAP_INST_ADDR_MISALIGNED 0
`define TRAP_INST_ACCESS_FAULT 1
`define TRAP_INST_PAGE_FAULT 12

`endif
